// ==== fetch_pkg.sv ====
package fetch_pkg;

    ////////////////////////////////////////////////////////////////////
    // line geometry
    ////////////////////////////////////////////////////////////////////

    localparam int LINE_BYTES = 16;  // bytes per cache line, one bank each

    ////////////////////////////////////////////////////////////////////
    // control flow
    ////////////////////////////////////////////////////////////////////

    // next pointer source, listed highest priority first
    typedef enum logic [1:0] {
        CF_INIT    = 2'd0,
        CF_RESTEER = 2'd1,  // writeback redirect
        CF_BRANCH  = 2'd2,  // predicted taken
        CF_SEQ     = 2'd3   // fall through
    } cf_src_e;

    ////////////////////////////////////////////////////////////////////
    // decoder bundle
    ////////////////////////////////////////////////////////////////////

    // two lines per fetch, 32 bytes in all
    typedef struct packed {
        logic [127:0] even_line;
        logic [127:0] odd_line;
        logic [31:0]  even_vaddr;  // line aligned
        logic [31:0]  odd_vaddr;
        logic [1:0]   fip_lsb;     // vaddr 5:4 of the lower line
        logic         tlb_miss;
        logic         prot_fault;
    } fetch_bundle_t;

endpackage

// ==== mem_pkg.sv ====
package mem_pkg;

    localparam int PADDR_W = 15;  // physical byte address width

    // one translation, vpn matched against vaddr 31:12
    typedef struct packed {
        logic [19:0] vpn;
        logic [19:0] pfn;
        logic        valid;
        logic        present;
        logic        pcd;    // uncacheable, no fetch allowed
    } tlb_entry_t;

    // bank to miss handler
    typedef struct packed {
        logic [PADDR_W-1:0] paddr;   // line aligned
        logic               parity;  // 0 even bank, 1 odd bank
    } miss_req_t;

    // returned line, written into the bank named by the fill enable
    typedef struct packed {
        logic [PADDR_W-1:0] paddr;
        logic [127:0]       data;
    } mem_fill_t;

    typedef enum logic [1:0] {
        MH_IDLE    = 2'd0,
        MH_REQ     = 2'd1,  // req high, waiting for ack
        MH_FILL    = 2'd2,  // one cycle bank write
        MH_RELEASE = 2'd3   // wait for ack to drop
    } miss_state_e;

endpackage

// ==== fetch_addr_select.sv ====
`timescale 1ns/1ps

module fetch_addr_select import fetch_pkg::*; #(
    parameter int PARITY = 0
) (
    input  logic        clk,
    input  logic        arst_n_i,
    input  logic        init_i,
    input  logic        resteer_i,
    input  logic        branch_i,
    input  logic [31:0] init_addr_i,
    input  logic [31:0] resteer_addr_i,
    input  logic [31:0] branch_addr_i,
    input  logic        take_i,
    output logic [31:0] vaddr_o,
    output logic        addr_valid_o
);

    localparam int OFF_W = $clog2(LINE_BYTES);

    cf_src_e     cf_src;
    logic [31:0] cf_addr;
    logic [31:0] cf_aligned;
    logic [31:0] cf_line;
    logic [31:0] next_addr;
    logic [31:0] addr_q;
    logic        started_q;
    logic        load;

    // fixed priority, init beats resteer beats branch
    always_comb begin
        if (init_i)
            cf_src = CF_INIT;
        else if (resteer_i)
            cf_src = CF_RESTEER;
        else if (branch_i)
            cf_src = CF_BRANCH;
        else
            cf_src = CF_SEQ;
    end

    always_comb begin
        case (cf_src)
            CF_INIT:    cf_addr = init_addr_i;
            CF_RESTEER: cf_addr = resteer_addr_i;
            CF_BRANCH:  cf_addr = branch_addr_i;
            default:    cf_addr = addr_q;
        endcase
    end

    // wrong parity at the target means our line is the next one up
    assign cf_aligned = {cf_addr[31:OFF_W], {OFF_W{1'b0}}};
    assign cf_line    = (cf_addr[OFF_W] == 1'(PARITY)) ? cf_aligned
                                                       : cf_aligned + 32'(LINE_BYTES);

    assign next_addr = (cf_src == CF_SEQ) ? addr_q + 32'(2 * LINE_BYTES) : cf_line;
    assign load      = (cf_src != CF_SEQ) || take_i;  // redirect overrides a take

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            addr_q    <= '0;
            started_q <= 1'b0;
        end else begin
            if (load)
                addr_q <= next_addr;
            if (init_i)
                started_q <= 1'b1;  // nothing is fetched before the first init
        end
    end

    assign vaddr_o      = addr_q;
    assign addr_valid_o = started_q;

endmodule

// ==== fetch_tlb.sv ====
`timescale 1ns/1ps

module fetch_tlb import mem_pkg::*; #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  logic                           we_i,
    input  logic [$clog2(TLB_ENTRIES)-1:0] idx_i,
    input  tlb_entry_t                     entry_i,
    input  logic [31:0]                    vaddr_i,
    output logic [PADDR_W-1:0]             paddr_o,
    output logic                           miss_o,
    output logic                           prot_fault_o
);

    tlb_entry_t               entry_q [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0]   valid_q;
    tlb_entry_t               match;
    logic                     hit;

    ////////////////////////////////////////////////////////////////////
    // entry storage
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (we_i) begin
            valid_q[idx_i] <= entry_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (we_i)
            entry_q[idx_i] <= entry_i;
    end

    ////////////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////////////

    // first matching entry wins, duplicates are not expected
    always_comb begin
        hit   = 1'b0;
        match = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (!hit && valid_q[i] && (entry_q[i].vpn == vaddr_i[31:12])) begin
                hit   = 1'b1;
                match = entry_q[i];
            end
        end
    end

    // only the low pfn bits reach the small physical space
    assign paddr_o = {match.pfn[PADDR_W-13:0], vaddr_i[11:0]};
    assign miss_o  = !hit;

    // uncacheable or absent page, refuse the fetch
    assign prot_fault_o = hit && (match.pcd || !match.present);

endmodule

// ==== icache_bank.sv ====
`timescale 1ns/1ps

module icache_bank import fetch_pkg::*, mem_pkg::*; #(
    parameter int PARITY   = 0,
    parameter int NUM_SETS = 8
) (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               lookup_i,       // address valid
    input  logic [PADDR_W-1:0] paddr_i,
    input  logic               xlate_fault_i,
    input  logic               fill_we_i,
    input  mem_fill_t          fill_i,
    output logic [127:0]       line_o,
    output logic               hit_o,
    output logic               miss_o,
    output miss_req_t          miss_req_o
);

    // bit OFF_W is the bank parity, so the index starts one above it
    localparam int OFF_W  = $clog2(LINE_BYTES);
    localparam int IDX_LO = OFF_W + 1;
    localparam int IDX_W  = $clog2(NUM_SETS);
    localparam int TAG_LO = IDX_LO + IDX_W;
    localparam int TAG_W  = PADDR_W - TAG_LO;

    logic [TAG_W-1:0]    tag_q  [NUM_SETS];
    logic [127:0]        data_q [NUM_SETS];
    logic [NUM_SETS-1:0] valid_q;

    logic [IDX_W-1:0]    rd_idx;
    logic [TAG_W-1:0]    rd_tag;
    logic [IDX_W-1:0]    wr_idx;
    logic [TAG_W-1:0]    wr_tag;
    logic                tag_match;

    ////////////////////////////////////////////////////////////////////
    // address split
    ////////////////////////////////////////////////////////////////////

    assign rd_idx = paddr_i[IDX_LO +: IDX_W];
    assign rd_tag = paddr_i[PADDR_W-1:TAG_LO];
    assign wr_idx = fill_i.paddr[IDX_LO +: IDX_W];
    assign wr_tag = fill_i.paddr[PADDR_W-1:TAG_LO];

    ////////////////////////////////////////////////////////////////////
    // fill write
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (fill_we_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we_i) begin
            tag_q[wr_idx]  <= wr_tag;
            data_q[wr_idx] <= fill_i.data;  // whole line, no partial fills
        end
    end

    ////////////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////////////

    assign tag_match = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

    // a translation fault means paddr is meaningless
    assign hit_o  = lookup_i && !xlate_fault_i && tag_match;
    assign miss_o = lookup_i && !xlate_fault_i && !tag_match;  // held until the fill lands
    assign line_o = data_q[rd_idx];

    // request the whole line
    assign miss_req_o.paddr  = {paddr_i[PADDR_W-1:OFF_W], {OFF_W{1'b0}}};
    assign miss_req_o.parity = 1'(PARITY);

endmodule

// ==== miss_handler.sv ====
`timescale 1ns/1ps

module miss_handler import mem_pkg::*; (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               miss_even_i,
    input  logic               miss_odd_i,
    input  miss_req_t          req_even_i,
    input  miss_req_t          req_odd_i,
    output logic               mem_req_o,
    output logic [PADDR_W-1:0] mem_paddr_o,
    input  logic               mem_ack_i,
    input  logic [127:0]       mem_data_i,
    output mem_fill_t          fill_o,
    output logic               fill_we_even_o,
    output logic               fill_we_odd_o
);

    miss_state_e  state_q;
    miss_state_e  state_d;
    miss_req_t    req_q;   // request in flight
    logic [127:0] data_q;

    ////////////////////////////////////////////////////////////////////
    // four-phase sequencing
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            MH_IDLE: begin
                if (miss_even_i || miss_odd_i)
                    state_d = MH_REQ;
            end
            MH_REQ: begin
                if (mem_ack_i)
                    state_d = MH_FILL;  // data captured on this edge
            end
            MH_FILL: begin
                state_d = MH_RELEASE;
            end
            MH_RELEASE: begin
                // memory must drop ack before the next req
                if (!mem_ack_i)
                    state_d = MH_IDLE;
            end
            default: state_d = MH_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i)
            state_q <= MH_IDLE;
        else
            state_q <= state_d;
    end

    // even wins a tie
    always_ff @(posedge clk) begin
        if (state_q == MH_IDLE && miss_even_i)
            req_q <= req_even_i;
        else if (state_q == MH_IDLE && miss_odd_i)
            req_q <= req_odd_i;

        if (state_q == MH_REQ && mem_ack_i)
            data_q <= mem_data_i;
    end

    ////////////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////////////

    assign mem_req_o   = (state_q == MH_REQ);
    assign mem_paddr_o = req_q.paddr;  // stable for the whole REQ phase

    assign fill_o = '{paddr: req_q.paddr, data: data_q};

    // one pulse per fill, to the bank that asked
    assign fill_we_even_o = (state_q == MH_FILL) && !req_q.parity;
    assign fill_we_odd_o  = (state_q == MH_FILL) && req_q.parity;

endmodule

// ==== fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*, mem_pkg::*; #(
    parameter int NUM_SETS    = 8,
    parameter int TLB_ENTRIES = 8
) (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  logic                           init_i,
    input  logic [31:0]                    init_addr_i,
    input  logic                           resteer_i,
    input  logic [31:0]                    resteer_addr_i,
    input  logic                           branch_i,
    input  logic [31:0]                    branch_addr_i,
    input  logic                           tlb_we_i,
    input  logic [$clog2(TLB_ENTRIES)-1:0] tlb_idx_i,
    input  tlb_entry_t                     tlb_entry_i,
    output logic                           fetch_valid_o,
    output fetch_bundle_t                  fetch_o,
    input  logic                           fetch_take_i,
    output logic                           mem_req_o,
    output logic [PADDR_W-1:0]             mem_paddr_o,
    input  logic                           mem_ack_i,
    input  logic [127:0]                   mem_data_i
);

    logic [31:0]        vaddr_e, vaddr_o;
    logic               avalid_e, avalid_o;
    logic [PADDR_W-1:0] paddr_e, paddr_o;
    logic               tmiss_e, tmiss_o;
    logic               pfault_e, pfault_o;
    logic               fault_e, fault_o;
    logic [127:0]       line_e, line_o;
    logic               hit_e, hit_o;
    logic               miss_e, miss_o;
    miss_req_t          mreq_e, mreq_o;
    mem_fill_t          fill;
    logic               fill_we_e, fill_we_o;

    ////////////////////////////////////////////////////////////////////
    // even side
    ////////////////////////////////////////////////////////////////////

    fetch_addr_select #(.PARITY(0)) u_sel_even (
        .clk(clk), .arst_n_i(arst_n_i),
        .init_i(init_i), .resteer_i(resteer_i), .branch_i(branch_i),
        .init_addr_i(init_addr_i), .resteer_addr_i(resteer_addr_i),
        .branch_addr_i(branch_addr_i), .take_i(fetch_take_i),
        .vaddr_o(vaddr_e), .addr_valid_o(avalid_e)
    );

    fetch_tlb #(.TLB_ENTRIES(TLB_ENTRIES)) u_tlb_even (
        .clk(clk), .arst_n_i(arst_n_i), .we_i(tlb_we_i), .idx_i(tlb_idx_i),
        .entry_i(tlb_entry_i), .vaddr_i(vaddr_e), .paddr_o(paddr_e),
        .miss_o(tmiss_e), .prot_fault_o(pfault_e)
    );

    icache_bank #(.PARITY(0), .NUM_SETS(NUM_SETS)) u_bank_even (
        .clk(clk), .arst_n_i(arst_n_i), .lookup_i(avalid_e), .paddr_i(paddr_e),
        .xlate_fault_i(fault_e), .fill_we_i(fill_we_e), .fill_i(fill),
        .line_o(line_e), .hit_o(hit_e), .miss_o(miss_e), .miss_req_o(mreq_e)
    );

    ////////////////////////////////////////////////////////////////////
    // odd side
    ////////////////////////////////////////////////////////////////////

    fetch_addr_select #(.PARITY(1)) u_sel_odd (
        .clk(clk), .arst_n_i(arst_n_i),
        .init_i(init_i), .resteer_i(resteer_i), .branch_i(branch_i),
        .init_addr_i(init_addr_i), .resteer_addr_i(resteer_addr_i),
        .branch_addr_i(branch_addr_i), .take_i(fetch_take_i),
        .vaddr_o(vaddr_o), .addr_valid_o(avalid_o)
    );

    fetch_tlb #(.TLB_ENTRIES(TLB_ENTRIES)) u_tlb_odd (
        .clk(clk), .arst_n_i(arst_n_i), .we_i(tlb_we_i), .idx_i(tlb_idx_i),
        .entry_i(tlb_entry_i), .vaddr_i(vaddr_o), .paddr_o(paddr_o),
        .miss_o(tmiss_o), .prot_fault_o(pfault_o)
    );

    icache_bank #(.PARITY(1), .NUM_SETS(NUM_SETS)) u_bank_odd (
        .clk(clk), .arst_n_i(arst_n_i), .lookup_i(avalid_o), .paddr_i(paddr_o),
        .xlate_fault_i(fault_o), .fill_we_i(fill_we_o), .fill_i(fill),
        .line_o(line_o), .hit_o(hit_o), .miss_o(miss_o), .miss_req_o(mreq_o)
    );

    miss_handler u_miss (
        .clk(clk), .arst_n_i(arst_n_i),
        .miss_even_i(miss_e), .miss_odd_i(miss_o),
        .req_even_i(mreq_e), .req_odd_i(mreq_o),
        .mem_req_o(mem_req_o), .mem_paddr_o(mem_paddr_o),
        .mem_ack_i(mem_ack_i), .mem_data_i(mem_data_i),
        .fill_o(fill), .fill_we_even_o(fill_we_e), .fill_we_odd_o(fill_we_o)
    );

    ////////////////////////////////////////////////////////////////////
    // decoder side
    ////////////////////////////////////////////////////////////////////

    assign fault_e = tmiss_e || pfault_e;
    assign fault_o = tmiss_o || pfault_o;

    // each bank done, by a hit or by an exception
    assign fetch_valid_o = avalid_e && avalid_o && (hit_e || fault_e) && (hit_o || fault_o);

    assign fetch_o = '{
        even_line:  line_e,
        odd_line:   line_o,
        even_vaddr: vaddr_e,
        odd_vaddr:  vaddr_o,
        fip_lsb:    (vaddr_o < vaddr_e) ? vaddr_o[5:4] : vaddr_e[5:4],  // lower line first
        tlb_miss:   tmiss_e || tmiss_o,
        prot_fault: pfault_e || pfault_o
    };

endmodule

// ==== tb_mem_model.sv ====
`timescale 1ns/1ps

module tb_mem_model import mem_pkg::*; (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               mem_req_i,
    input  logic [PADDR_W-1:0] mem_paddr_i,
    output logic               mem_ack_o,
    output logic [127:0]       mem_data_o
);

    int delay;  // cycles left before ack
    bit busy;

    // word k of the line at p holds p + k
    function automatic logic [127:0] line_at(input logic [PADDR_W-1:0] p);
        logic [127:0] l;
        for (int k = 0; k < 4; k++)
            l[32*k +: 32] = 32'(p) + 32'(k);
        return l;
    endfunction

    initial begin
        mem_ack_o  = 1'b0;
        mem_data_o = '0;
        busy       = 1'b0;
        delay      = 0;
        void'($urandom(80));
        forever begin
            @(posedge clk);
            #1;
            if (!arst_n_i) begin
                mem_ack_o = 1'b0;
                busy      = 1'b0;
            end else if (mem_ack_o) begin
                if (!mem_req_i)
                    mem_ack_o = 1'b0;  // req dropped, close the handshake
            end else if (busy) begin
                if (delay == 0) begin
                    mem_data_o = line_at(mem_paddr_i);
                    mem_ack_o  = 1'b1;
                    busy       = 1'b0;
                end else begin
                    delay--;
                end
            end else if (mem_req_i) begin
                delay = $urandom % 8;
                busy  = 1'b1;
            end
        end
    end

endmodule

// ==== tb_fetch_top.sv ====
`timescale 1ns/1ps

module tb_fetch_top import fetch_pkg::*, mem_pkg::*; ();

    localparam int         WAIT_LIMIT = 200;
    localparam logic [2:0] PFN_PAGE1  = 3'd5;  // low pfn bits of page 1

    logic               clk;
    logic               arst_n_i;
    logic               init_i;
    logic               resteer_i;
    logic               branch_i;
    logic [31:0]        init_addr_i;
    logic [31:0]        resteer_addr_i;
    logic [31:0]        branch_addr_i;
    logic               tlb_we_i;
    logic [2:0]         tlb_idx_i;
    tlb_entry_t         tlb_entry_i;
    logic               fetch_valid_o;
    fetch_bundle_t      fetch_o;
    logic               fetch_take_i;
    logic               mem_req_o;
    logic [PADDR_W-1:0] mem_paddr_o;
    logic               mem_ack_i;
    logic [127:0]       mem_data_i;

    int            errors    = 0;
    int            checks    = 0;
    int            req_rises = 0;
    bit            timed_out = 1'b0;
    int            rises0;
    fetch_bundle_t snap;

    logic               req_prev = 1'b0;
    logic [PADDR_W-1:0] paddr_prev;

    fetch_top fetch_top_inst (.*);

    tb_mem_model u_mem (
        .clk(clk), .arst_n_i(arst_n_i), .mem_req_i(mem_req_o), .mem_paddr_i(mem_paddr_o),
        .mem_ack_o(mem_ack_i), .mem_data_o(mem_data_i)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge mem_req_o) req_rises++;

    //////////////////////////////////////////////////////////////////////
    // expected values
    //////////////////////////////////////////////////////////////////////

    function automatic logic [127:0] expected_line(input logic [PADDR_W-1:0] p);
        logic [127:0] l;
        for (int k = 0; k < 4; k++)
            l[32*k +: 32] = 32'(p) + 32'(k);
        return l;
    endfunction

    function automatic logic [PADDR_W-1:0] phys_of(input logic [31:0] v);
        return {PFN_PAGE1, v[11:0]};
    endfunction

    // line of the given parity for a target address
    function automatic logic [31:0] line_for(input logic [31:0] a, input bit parity);
        logic [31:0] base;
        base = {a[31:4], 4'h0};
        if (a[4] == parity)
            return base;
        return base + 32'd16;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // checks and stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic check_val(input logic [127:0] got, input logic [127:0] exp,
                             input string what);
        checks++;
        assert (got === exp)
        else begin
            $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    // address held stable and req raised only once ack is low
    always @(negedge clk) begin
        if (mem_req_o && req_prev)
            check_val(mem_paddr_o, paddr_prev, "mem_paddr_o during request");
        if (mem_req_o && !req_prev) begin
            check_val(mem_ack_i, 1'b0, "mem_ack_i at request rise");
            check_val(mem_paddr_o[3:0], 4'h0, "mem_paddr_o line alignment");
        end
        req_prev   = mem_req_o;
        paddr_prev = mem_paddr_o;
    end

    // a: first line of the fetch, page 1 only
    task automatic check_fetch(input logic [31:0] a);
        check_val(fetch_o.even_vaddr, line_for(a, 1'b0), "even_vaddr");
        check_val(fetch_o.odd_vaddr, line_for(a, 1'b1), "odd_vaddr");
        check_val(fetch_o.even_line, expected_line(phys_of(line_for(a, 1'b0))), "even_line");
        check_val(fetch_o.odd_line, expected_line(phys_of(line_for(a, 1'b1))), "odd_line");
        check_val(fetch_o.fip_lsb, a[5:4], "fip_lsb");
        check_val(fetch_o.tlb_miss, 1'b0, "tlb_miss");
        check_val(fetch_o.prot_fault, 1'b0, "prot_fault");
    endtask

    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_valid(input string what);
        int n;
        n = 0;
        while (!fetch_valid_o && n < WAIT_LIMIT && !timed_out) begin
            step(1);
            n++;
        end
        if (!fetch_valid_o) begin
            if (!timed_out)
                $display("timeout: fetch_valid_o never rose for %s", what);
            timed_out = 1'b1;
        end
    endtask

    task automatic write_tlb(input logic [2:0] idx, input logic [19:0] vpn,
                             input logic [19:0] pfn, input bit pcd);
        step(1);
        tlb_we_i            = 1'b1;
        tlb_idx_i           = idx;
        tlb_entry_i.vpn     = vpn;
        tlb_entry_i.pfn     = pfn;
        tlb_entry_i.valid   = 1'b1;
        tlb_entry_i.present = 1'b1;
        tlb_entry_i.pcd     = pcd;
        step(1);
        tlb_we_i = 1'b0;
    endtask

    task automatic pulse_init(input logic [31:0] a);
        step(1);
        init_i      = 1'b1;
        init_addr_i = a;
        step(1);
        init_i = 1'b0;  // pointer loaded on that edge
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        if (errors == err_before && !timed_out)
            $display("test %0d %s: passed", num, name);
        else
            $display("test %0d %s: failed", num, name);
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int e0;
        arst_n_i       = 1'b0;
        init_i         = 1'b0;
        resteer_i      = 1'b0;
        branch_i       = 1'b0;
        init_addr_i    = '0;
        resteer_addr_i = '0;
        branch_addr_i  = '0;
        tlb_we_i       = 1'b0;
        tlb_idx_i      = '0;
        tlb_entry_i    = '0;
        fetch_take_i   = 1'b0;

        e0 = errors;
        repeat (10) begin
            step(1);
            check_val(mem_req_o, 1'b0, "mem_req_o in reset");
            check_val(fetch_valid_o, 1'b0, "fetch_valid_o in reset");
        end
        arst_n_i = 1'b1;
        write_tlb(3'd0, 20'h1, 20'h5, 1'b0);
        write_tlb(3'd1, 20'h2, 20'h6, 1'b1);  // uncacheable page
        repeat (4) begin
            step(1);
            check_val(mem_req_o, 1'b0, "mem_req_o before init");
            check_val(fetch_valid_o, 1'b0, "fetch_valid_o before init");
        end
        report_test(1, "quiet until init", e0);

        e0 = errors;
        pulse_init(32'h1010);
        wait_valid("init 0x1010");
        check_fetch(32'h1010);
        report_test(2, "init fetch", e0);

        e0 = errors;
        snap = fetch_o;
        step(3);  // no take, bundle must hold
        check_val(fetch_valid_o, 1'b1, "fetch_valid_o under back-pressure");
        check_val(fetch_o === snap, 1'b1, "fetch_o stable under back-pressure");
        fetch_take_i = 1'b1;
        step(1);
        fetch_take_i = 1'b0;
        wait_valid("take");
        check_fetch(32'h1030);
        report_test(3, "take advances 32 bytes", e0);

        e0 = errors;
        step(1);
        resteer_i      = 1'b1;
        resteer_addr_i = 32'h1080;
        branch_i       = 1'b1;
        branch_addr_i  = 32'h1200;
        step(1);
        resteer_i = 1'b0;
        branch_i  = 1'b0;
        wait_valid("resteer");
        check_fetch(32'h1080);
        report_test(4, "resteer over branch", e0);

        e0 = errors;
        rises0 = req_rises;
        pulse_init(32'h1010);
        wait_valid("re-init 0x1010");
        check_fetch(32'h1010);
        check_val(req_rises, rises0, "memory requests on re-init");
        report_test(5, "re-init hits", e0);

        e0 = errors;
        rises0 = req_rises;
        pulse_init(32'h3000);
        wait_valid("unmapped page");
        check_val(fetch_o.tlb_miss, 1'b1, "tlb_miss on unmapped page");
        check_val(fetch_o.prot_fault, 1'b0, "prot_fault on unmapped page");
        step(3);
        pulse_init(32'h2000);
        wait_valid("uncacheable page");
        check_val(fetch_o.tlb_miss, 1'b0, "tlb_miss on page 2");
        check_val(fetch_o.prot_fault, 1'b1, "prot_fault on page 2");
        step(3);
        check_val(req_rises, rises0, "memory requests on faults");
        report_test(6, "translation faults", e0);

        $display("%0d checks, %0d mismatches, timeout %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// ==== verilog.f ====
fetch_pkg.sv
mem_pkg.sv
fetch_addr_select.sv
fetch_tlb.sv
icache_bank.sv
miss_handler.sv
fetch_top.sv
tb_mem_model.sv
tb_fetch_top.sv
